// ==== hw/mem_pkg.sv ====
// memory back end shared types: widths, memory-op encoding and stage buses
package mem_pkg;

  typedef logic [63:0] word_t;      // gpr / data word
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  mem_op_t;    // funct3 of the load/store
  typedef logic [63:0] sram_line_t;
  typedef logic [7:0]  sram_strb_t;

  // size field, mem_op[1:0]
  localparam logic [1:0] MEM_SZ_B = 2'b00;
  localparam logic [1:0] MEM_SZ_H = 2'b01;
  localparam logic [1:0] MEM_SZ_W = 2'b10;
  localparam logic [1:0] MEM_SZ_D = 2'b11;
  localparam int         MEM_OP_U = 2;  // unsigned load bit

  // instruction leaving execute
  typedef struct packed {
    gpr_addr_t rd;
    csr_addr_t csr;
    logic      gpr_wen;
    logic      csr_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_op_t   mem_op;
    logic      csr_inst_sel;  // gpr gets the old csr value
    word_t     csr_rdata;
    word_t     alu_result;    // doubles as mem address
    word_t     store_data;
    word_t     csr_result;
  } es_to_ms_t;

  typedef struct packed {
    logic      gpr_wen;
    gpr_addr_t rd;
    word_t     gpr_data;
    logic      csr_wen;
    csr_addr_t csr;
    word_t     csr_data;
  } ms_to_ws_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t rd;
    logic      ready;  // data already valid
    word_t     data;
  } bypass_t;

  typedef struct packed {
    logic       req;
    logic       wr;
    word_t      addr;
    sram_strb_t wstrb;
    sram_line_t wdata;
  } sram_req_t;

endpackage

// ==== hw/lsu_store.sv ====
// store unit: forms the data sram request with byte strobes and lane-replicated write data
`timescale 1ns/1ps

module lsu_store (
  input  logic               i_accept,
  input  mem_pkg::es_to_ms_t i_es,
  output mem_pkg::sram_req_t o_req
);

  import mem_pkg::*;

  logic [2:0] byte_off;
  sram_strb_t size_mask;
  sram_line_t lane_data;

  assign byte_off = i_es.alu_result[2:0];

  // strobe pattern at lane 0 and data copied into every lane of its size
  always_comb begin
    case (i_es.mem_op[1:0])
      MEM_SZ_B: begin
        size_mask = 8'h01;
        lane_data = {8{i_es.store_data[7:0]}};
      end
      MEM_SZ_H: begin
        size_mask = 8'h03;
        lane_data = {4{i_es.store_data[15:0]}};
      end
      MEM_SZ_W: begin
        size_mask = 8'h0f;
        lane_data = {2{i_es.store_data[31:0]}};
      end
      default: begin  // double
        size_mask = 8'hff;
        lane_data = i_es.store_data;
      end
    endcase
  end

  always_comb begin
    o_req.req   = i_accept && (i_es.mem_ren || i_es.mem_wen);  // only in the accept cycle
    o_req.wr    = i_es.mem_wen;
    o_req.addr  = {i_es.alu_result[63:3], 3'b000};  // line aligned
    o_req.wstrb = i_es.mem_wen ? sram_strb_t'(size_mask << byte_off) : '0;
    o_req.wdata = i_es.mem_wen ? lane_data : '0;
  end

endmodule

// ==== hw/lsu_load.sv ====
// load unit: picks the addressed byte/half/word/double out of the read line and extends it
`timescale 1ns/1ps

module lsu_load (
  input  logic [2:0]          i_addr_low,
  input  mem_pkg::sram_line_t i_rdata,
  input  mem_pkg::mem_op_t    i_mem_op,
  output mem_pkg::word_t      o_rdata
);

  import mem_pkg::*;

  sram_line_t shifted;
  logic       is_unsigned;
  logic       sign;

  assign shifted     = i_rdata >> {i_addr_low, 3'b000};  // addressed byte to lane 0
  assign is_unsigned = i_mem_op[MEM_OP_U];

  always_comb begin
    case (i_mem_op[1:0])
      MEM_SZ_B: begin
        sign    = !is_unsigned && shifted[7];
        o_rdata = {{56{sign}}, shifted[7:0]};
      end
      MEM_SZ_H: begin
        sign    = !is_unsigned && shifted[15];
        o_rdata = {{48{sign}}, shifted[15:0]};
      end
      MEM_SZ_W: begin
        sign    = !is_unsigned && shifted[31];
        o_rdata = {{32{sign}}, shifted[31:0]};
      end
      default: begin
        sign    = 1'b0;  // full width, nothing to extend
        o_rdata = shifted;
      end
    endcase
  end

endmodule

// ==== hw/mem_stage.sv ====
// memory stage: holds one instruction, waits for data_ok, selects the result and drives bypass
`timescale 1ns/1ps

module mem_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  // from execute
  input  logic                i_es_to_ms_valid,
  input  mem_pkg::es_to_ms_t  i_es_to_ms_bus,
  output logic                o_ms_allowin,
  output logic                o_accept,
  // to write-back
  input  logic                i_ws_allowin,
  output logic                o_ms_to_ws_valid,
  output mem_pkg::ms_to_ws_t  o_ms_to_ws_bus,
  // data sram response
  input  logic                i_sram_data_ok,
  input  mem_pkg::sram_line_t i_sram_rdata,
  output mem_pkg::bypass_t    o_bypass
);

  import mem_pkg::*;

  logic       ms_valid;
  es_to_ms_t  ms_r;
  logic       ms_mem;
  logic       ms_ready_go;
  logic       ms_handoff;
  logic       dok_seen;  // data_ok already arrived for this instruction
  sram_line_t line_buf;
  sram_line_t load_line;
  word_t      load_data;
  word_t      gpr_result;
  logic       byp_wen;

  assign ms_mem           = ms_r.mem_ren || ms_r.mem_wen;
  assign ms_ready_go      = ms_mem ? (i_sram_data_ok || dok_seen) : 1'b1;
  assign o_ms_allowin     = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign o_accept         = i_es_to_ms_valid && o_ms_allowin;
  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;
  assign ms_handoff       = o_ms_to_ws_valid && i_ws_allowin;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_to_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_accept) begin
      ms_r <= i_es_to_ms_bus;
    end
  end

  // keeps ready_go up after the one-cycle data_ok while write-back stalls
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dok_seen <= 1'b0;
    end else if (ms_handoff) begin
      dok_seen <= 1'b0;
    end else if (ms_valid && ms_mem && i_sram_data_ok) begin
      dok_seen <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_sram_data_ok) begin
      line_buf <= i_sram_rdata;
    end
  end

  assign load_line = dok_seen ? line_buf : i_sram_rdata;

  lsu_load u_lsu_load (
    .i_addr_low (ms_r.alu_result[2:0]),
    .i_rdata    (load_line),
    .i_mem_op   (ms_r.mem_op),
    .o_rdata    (load_data)
  );

  assign gpr_result = ms_r.mem_ren ? load_data
                    : (ms_r.csr_inst_sel ? ms_r.csr_rdata : ms_r.alu_result);

  always_comb begin
    o_ms_to_ws_bus.gpr_wen  = ms_r.gpr_wen;
    o_ms_to_ws_bus.rd       = ms_r.rd;
    o_ms_to_ws_bus.gpr_data = gpr_result;
    o_ms_to_ws_bus.csr_wen  = ms_r.csr_wen;
    o_ms_to_ws_bus.csr      = ms_r.csr;
    o_ms_to_ws_bus.csr_data = ms_r.csr_result;
  end

  // bypass to decode
  assign byp_wen = ms_valid && ms_r.gpr_wen;

  always_comb begin
    o_bypass.wen   = byp_wen;
    o_bypass.rd    = byp_wen ? ms_r.rd : '0;
    o_bypass.ready = byp_wen && (!ms_r.mem_ren || ms_ready_go);  // load waits for data
    o_bypass.data  = byp_wen ? gpr_result : '0;
  end

endmodule

// ==== hw/wb_stage.sv ====
// write-back stage: holds the retiring instruction and drives the gpr and csr write ports
`timescale 1ns/1ps

module wb_stage (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  logic               i_ms_to_ws_valid,
  input  mem_pkg::ms_to_ws_t i_ms_to_ws_bus,
  input  logic               i_stall,  // register file port busy
  output logic               o_ws_allowin,
  output logic               o_retire,
  output logic               o_gpr_wen,
  output mem_pkg::gpr_addr_t o_rd,
  output mem_pkg::word_t     o_gpr_data,
  output logic               o_csr_wen,
  output mem_pkg::csr_addr_t o_csr,
  output mem_pkg::word_t     o_csr_data
);

  import mem_pkg::*;

  typedef enum logic {
    ws_idle,
    ws_hold
  } ws_state_e;

  ws_state_e state;
  ws_state_e state_nxt;
  ms_to_ws_t ws_r;
  logic      ws_valid;

  assign ws_valid     = (state == ws_hold);
  assign o_retire     = ws_valid && !i_stall;
  assign o_ws_allowin = !ws_valid || !i_stall;  // held instruction blocks the stage

  always_comb begin
    state_nxt = state;
    case (state)
      ws_idle: begin
        if (i_ms_to_ws_valid) begin
          state_nxt = ws_hold;
        end
      end
      ws_hold: begin
        // retiring with nothing behind it
        if (!i_stall && !i_ms_to_ws_valid) begin
          state_nxt = ws_idle;
        end
      end
      default: state_nxt = ws_idle;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= ws_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ms_to_ws_valid && o_ws_allowin) begin
      ws_r <= i_ms_to_ws_bus;
    end
  end

  assign o_gpr_wen  = o_retire && ws_r.gpr_wen;
  assign o_rd       = ws_r.rd;
  assign o_gpr_data = ws_r.gpr_data;
  assign o_csr_wen  = o_retire && ws_r.csr_wen;
  assign o_csr      = ws_r.csr;
  assign o_csr_data = ws_r.csr_data;

endmodule

// ==== hw/mem_backend_top.sv ====
// memory back end top: store request forming, memory stage and write-back
`timescale 1ns/1ps

module mem_backend_top (
  input  logic                i_clk,
  input  logic                i_arst_n,
  // execute interface
  input  logic                i_es_to_ms_valid,
  input  mem_pkg::es_to_ms_t  i_es_to_ms_bus,
  output logic                o_ms_allowin,
  // data sram
  output mem_pkg::sram_req_t  o_sram_req,
  input  logic                i_sram_data_ok,
  input  mem_pkg::sram_line_t i_sram_rdata,
  // decode bypass
  output mem_pkg::bypass_t    o_bypass,
  // write-back ports
  input  logic                i_ws_stall,
  output logic                o_ws_retire,
  output logic                o_ws_gpr_wen,
  output mem_pkg::gpr_addr_t  o_ws_rd,
  output mem_pkg::word_t      o_ws_gpr_data,
  output logic                o_ws_csr_wen,
  output mem_pkg::csr_addr_t  o_ws_csr,
  output mem_pkg::word_t      o_ws_csr_data
);

  import mem_pkg::*;

  logic      ms_accept;
  logic      ws_allowin;
  logic      ms_to_ws_valid;
  ms_to_ws_t ms_to_ws_bus;

  lsu_store u_lsu_store (
    .i_accept (ms_accept),  // request goes out with the accept
    .i_es     (i_es_to_ms_bus),
    .o_req    (o_sram_req)
  );

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_es_to_ms_valid (i_es_to_ms_valid),
    .i_es_to_ms_bus   (i_es_to_ms_bus),
    .o_ms_allowin     (o_ms_allowin),
    .o_accept         (ms_accept),
    .i_ws_allowin     (ws_allowin),
    .o_ms_to_ws_valid (ms_to_ws_valid),
    .o_ms_to_ws_bus   (ms_to_ws_bus),
    .i_sram_data_ok   (i_sram_data_ok),
    .i_sram_rdata     (i_sram_rdata),
    .o_bypass         (o_bypass)
  );

  wb_stage u_wb_stage (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_ms_to_ws_valid (ms_to_ws_valid),
    .i_ms_to_ws_bus   (ms_to_ws_bus),
    .i_stall          (i_ws_stall),
    .o_ws_allowin     (ws_allowin),
    .o_retire         (o_ws_retire),
    .o_gpr_wen        (o_ws_gpr_wen),
    .o_rd             (o_ws_rd),
    .o_gpr_data       (o_ws_gpr_data),
    .o_csr_wen        (o_ws_csr_wen),
    .o_csr            (o_ws_csr),
    .o_csr_data       (o_ws_csr_data)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// testbench clock and reset: 100 ns clock, reset held low for the first 10 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;  // released between edges
  end

endmodule

// ==== verif/tb_sram_model.sv ====
// behavioral data sram: one request at a time, byte-strobe writes, data_ok after 1 to 4 cycles
`timescale 1ns/1ps

module tb_sram_model #(
  parameter int LINES = 256
) (
  input  logic                i_clk,
  input  mem_pkg::sram_req_t  i_req,
  output logic                o_data_ok,
  output mem_pkg::sram_line_t o_rdata
);

  import mem_pkg::*;

  sram_line_t mem [0:LINES-1];
  int         idx;
  int         cnt;  // cycles left until data_ok

  initial begin
    for (int i = 0; i < LINES; i++) begin
      mem[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);  // every byte depends on the index
    end
    o_data_ok = 1'b0;
    o_rdata   = '0;
    idx       = 0;
    cnt       = 0;
  end

  always @(posedge i_clk) begin
    if (i_req.req) begin
      idx = int'(i_req.addr[10:3]) % LINES;
      cnt = int'($urandom_range(4, 1));
      if (i_req.wr) begin
        for (int b = 0; b < 8; b++) begin
          if (i_req.wstrb[b]) begin
            mem[idx][b*8 +: 8] = i_req.wdata[b*8 +: 8];
          end
        end
      end
    end else if (cnt != 0) begin
      cnt = cnt - 1;
    end
  end

  // response changes on the falling edge
  always @(negedge i_clk) begin
    o_data_ok = (cnt == 1);
    if (cnt == 1) begin
      o_rdata = mem[idx];
    end
  end

endmodule

// ==== verif/tb_mem_backend.sv ====
// memory back end testbench with random instruction mixes checked against a shadow memory
`timescale 1ns/1ps

module tb_mem_backend;

  import mem_pkg::*;

  localparam int TIMEOUT = 200;  // cycles per wait

  logic       clk, arst_n, es_valid, ms_allowin, data_ok, ws_stall, stall_on;
  es_to_ms_t  es_bus;
  sram_req_t  sram_req;
  sram_line_t rdata;
  bypass_t    bypass;
  logic       retire, gpr_wen, csr_wen;
  gpr_addr_t  rd;
  csr_addr_t  csr;
  word_t      gpr_data, csr_data;
  ms_to_ws_t  retire_bus;
  sram_line_t shadow [0:255];
  ms_to_ws_t  exp_mem [0:255];  // accepted and not yet retired
  logic [7:0] wr_ptr, rd_ptr;
  logic       newest_load, dok_since, sram_busy;
  int         errors, timeouts, n_tests, n_accepted, n_retired, gap_max;

  tb_clk_gen u_clk (.o_clk(clk), .o_arst_n(arst_n));

  tb_sram_model #(.LINES(256)) u_sram (
    .i_clk(clk), .i_req(sram_req), .o_data_ok(data_ok), .o_rdata(rdata)
  );

  mem_backend_top DUT (
    .i_clk(clk), .i_arst_n(arst_n), .i_es_to_ms_valid(es_valid), .i_es_to_ms_bus(es_bus),
    .o_ms_allowin(ms_allowin), .o_sram_req(sram_req), .i_sram_data_ok(data_ok),
    .i_sram_rdata(rdata), .o_bypass(bypass), .i_ws_stall(ws_stall), .o_ws_retire(retire),
    .o_ws_gpr_wen(gpr_wen), .o_ws_rd(rd), .o_ws_gpr_data(gpr_data), .o_ws_csr_wen(csr_wen),
    .o_ws_csr(csr), .o_ws_csr_data(csr_data)
  );

  assign retire_bus = {gpr_wen, rd, gpr_data, csr_wen, csr, csr_data};

  task automatic flag_mismatch(string msg);
    $display("Fail %0t ns: %s", $time, msg);
    errors++;
  endtask

  function automatic word_t predict_load(word_t addr, mem_op_t op);
    sram_line_t line;
    word_t      v;
    int         nbytes;
    line   = shadow[addr[10:3]];
    nbytes = 1 << op[1:0];
    v      = '0;
    for (int b = 0; b < nbytes; b++) begin
      v[b*8 +: 8] = line[(int'(addr[2:0]) + b)*8 +: 8];
    end
    if (!op[2] && nbytes < 8 && v[nbytes*8-1]) begin
      v = v | ~((64'd1 << (nbytes*8)) - 64'd1);  // sign fill
    end
    return v;
  endfunction

  function automatic ms_to_ws_t predict_retire(es_to_ms_t e);
    ms_to_ws_t p;
    p.gpr_wen  = e.gpr_wen;
    p.rd       = e.rd;
    p.gpr_data = e.mem_ren ? predict_load(e.alu_result, e.mem_op)
               : (e.csr_inst_sel ? e.csr_rdata : e.alu_result);
    p.csr_wen  = e.csr_wen;
    p.csr      = e.csr;
    p.csr_data = e.csr_result;
    return p;
  endfunction

  task automatic merge_store(es_to_ms_t e);
    for (int b = 0; b < (1 << e.mem_op[1:0]); b++) begin
      shadow[e.alu_result[10:3]][(int'(e.alu_result[2:0]) + b)*8 +: 8] = e.store_data[b*8 +: 8];
    end
  endtask

  function automatic bit request_matches(es_to_ms_t e, sram_req_t r);
    int n;
    int off;
    bit ok;
    n   = 1 << e.mem_op[1:0];
    off = int'(e.alu_result[2:0]);
    ok  = (r.addr == {e.alu_result[63:3], 3'b000}) && (r.wr == e.mem_wen);
    for (int b = 0; b < 8; b++) begin
      if (e.mem_wen && b >= off && b < off + n) begin
        ok = ok && r.wstrb[b] && (r.wdata[b*8 +: 8] == e.store_data[(b-off)*8 +: 8]);
      end else begin
        ok = ok && !r.wstrb[b];
      end
    end
    return ok;
  endfunction

  function automatic bit retire_matches(ms_to_ws_t got, ms_to_ws_t exp);
    return got.gpr_wen == exp.gpr_wen && got.csr_wen == exp.csr_wen
        && (!exp.gpr_wen || (got.rd == exp.rd && got.gpr_data == exp.gpr_data))
        && (!exp.csr_wen || (got.csr == exp.csr && got.csr_data == exp.csr_data));
  endfunction

  // scoreboard keeping the expected queue, shadow memory and sram state
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      newest_load <= 1'b0;
      dok_since   <= 1'b0;
      sram_busy   <= 1'b0;
      n_accepted  <= 0;
      n_retired   <= 0;
    end else begin
      if (es_valid && ms_allowin) begin
        exp_mem[wr_ptr] <= predict_retire(es_bus);
        if (es_bus.mem_wen) merge_store(es_bus);
        wr_ptr      <= wr_ptr + 8'd1;
        newest_load <= es_bus.mem_ren;
        dok_since   <= 1'b0;
        n_accepted  <= n_accepted + 1;
      end else if (data_ok) begin
        dok_since <= 1'b1;
      end
      if (data_ok) sram_busy <= 1'b0;
      if (sram_req.req) sram_busy <= 1'b1;
      if (retire) begin
        rd_ptr    <= rd_ptr + 8'd1;
        n_retired <= n_retired + 1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    retire |-> (rd_ptr != wr_ptr) && retire_matches(retire_bus, exp_mem[rd_ptr]))
    else flag_mismatch("retire does not match the oldest accepted instruction");
  assert property (@(posedge clk) disable iff (!arst_n)
    !retire |-> !gpr_wen && !csr_wen)
    else flag_mismatch("register write enable high without a retire");
  assert property (@(posedge clk) disable iff (!arst_n)
    sram_req.req == (es_valid && ms_allowin && (es_bus.mem_ren || es_bus.mem_wen)))
    else flag_mismatch("sram req not aligned with the accept of a memory instruction");
  assert property (@(posedge clk) disable iff (!arst_n)
    sram_req.req |-> request_matches(es_bus, sram_req))
    else flag_mismatch("sram address, strobes or lane data wrong");
  assert property (@(posedge clk) disable iff (!arst_n)
    sram_req.req |-> !sram_busy || data_ok)
    else flag_mismatch("second sram request while one is outstanding");
  assert property (@(posedge clk) disable iff (!arst_n)
    es_valid && ms_allowin && es_bus.gpr_wen |=> bypass.wen)
    else flag_mismatch("bypass wen low while a gpr writer sits in the memory stage");
  assert property (@(posedge clk) disable iff (!arst_n)
    !ms_allowin |-> bypass.wen == exp_mem[wr_ptr - 8'd1].gpr_wen)
    else flag_mismatch("bypass wen wrong while the memory stage holds an instruction");
  assert property (@(posedge clk) disable iff (!arst_n)
    bypass.wen |-> exp_mem[wr_ptr - 8'd1].gpr_wen && bypass.rd == exp_mem[wr_ptr - 8'd1].rd
      && bypass.ready == (!newest_load || dok_since || data_ok))
    else flag_mismatch("bypass rd or ready wrong");
  assert property (@(posedge clk) disable iff (!arst_n)
    bypass.ready |-> bypass.wen && bypass.data == exp_mem[wr_ptr - 8'd1].gpr_data)
    else flag_mismatch("bypass data wrong");

  always @(negedge clk) begin
    ws_stall = stall_on && ($urandom_range(3, 0) == 0);
  end

  function automatic es_to_ms_t random_inst(int kind, mem_op_t op, logic [2:0] off);
    es_to_ms_t e;
    e.rd           = 5'($urandom);
    e.csr          = 12'($urandom);
    e.gpr_wen      = (kind == 1) || (kind == 0 && 1'($urandom));
    e.csr_wen      = (kind == 0) && 1'($urandom);
    e.mem_ren      = (kind == 1);
    e.mem_wen      = (kind == 2);
    e.mem_op       = op;
    e.csr_inst_sel = 1'($urandom);
    e.csr_rdata    = {$urandom, $urandom};
    e.alu_result   = (kind == 0) ? {$urandom, $urandom} : {53'd0, 8'($urandom), off};
    e.store_data   = {$urandom, $urandom};
    e.csr_result   = {$urandom, $urandom};
    return e;
  endfunction

  function automatic logic [2:0] aligned_offset(mem_op_t op);
    return 3'($urandom) & ~3'((1 << op[1:0]) - 1);
  endfunction

  task automatic send_inst(es_to_ms_t e);
    int waited;
    int accepted_before;
    if (timeouts != 0) return;
    accepted_before = n_accepted;
    es_valid = 1'b1;
    es_bus   = e;
    waited   = 0;
    while (n_accepted == accepted_before && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (n_accepted == accepted_before) begin
      $display("timeout: memory stage never accepted the instruction");
      timeouts++;
    end
    es_valid = 1'b0;
    repeat ($urandom_range(gap_max, 0)) @(negedge clk);
  endtask

  task automatic finish_test(string name);
    int waited;
    waited = 0;
    while (rd_ptr != wr_ptr && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (rd_ptr != wr_ptr) begin
      $display("timeout: %0d instructions never retired", 8'(wr_ptr - rd_ptr));
      timeouts++;
    end
    n_tests++;
    $display("test %s done: accepted %0d retired %0d errors %0d", name, n_accepted, n_retired,
             errors);
  endtask

  initial begin
    es_to_ms_t st;
    es_to_ms_t ld;
    mem_op_t   op;
    int        kind;
    int        waited;
    void'($urandom(32'h2d344d38));
    es_valid = 1'b0;
    es_bus   = '0;
    ws_stall = 1'b0;
    stall_on = 1'b0;
    gap_max  = 0;
    errors   = 0;
    timeouts = 0;
    n_tests  = 0;
    waited   = 0;
    while (arst_n !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      timeouts++;
    end
    for (int i = 0; i < 256; i++) shadow[i] = u_sram.mem[i];
    @(negedge clk);
    assert (!retire && !sram_req.req && !bypass.wen && ms_allowin)
      else flag_mismatch("outputs not idle after reset");
    finish_test("reset");

    repeat (40) send_inst(random_inst(0, 3'd0, 3'd0));
    finish_test("alu_csr");

    for (int o = 0; o < 7; o++) begin  // lb lh lw ld lbu lhu lwu
      for (int off = 0; off < 8; off += 1 << o[1:0]) begin
        send_inst(random_inst(1, mem_op_t'(o), 3'(off)));
      end
    end
    finish_test("loads");

    for (int sz = 0; sz < 4; sz++) begin
      for (int off = 0; off < 8; off += 1 << sz) begin
        st = random_inst(2, mem_op_t'(sz), 3'(off));
        ld = random_inst(1, 3'd3, 3'd0);
        ld.alu_result = {st.alu_result[63:3], 3'b000};  // whole merged line back
        send_inst(st);
        send_inst(ld);
      end
    end
    finish_test("stores");

    stall_on = 1'b1;
    gap_max  = 2;
    repeat (200) begin
      kind = int'($urandom_range(2, 0));
      op   = (kind == 2) ? mem_op_t'($urandom_range(3, 0)) : mem_op_t'($urandom_range(6, 0));
      send_inst(random_inst(kind, op, aligned_offset(op)));
    end
    finish_test("random");

    gap_max = 0;
    repeat (60) begin
      op = mem_op_t'($urandom_range(6, 0));
      send_inst(random_inst(int'($urandom_range(1, 0)), op, aligned_offset(op)));
    end
    finish_test("bypass");

    $display("tests %0d accepted %0d retired %0d errors %0d timeouts %0d", n_tests,
             n_accepted, n_retired, errors, timeouts);
    if (errors == 0 && timeouts == 0 && n_accepted == n_retired) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hw/mem_pkg.sv
hw/lsu_store.sv
hw/lsu_load.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_backend_top.sv
verif/tb_clk_gen.sv
verif/tb_sram_model.sv
verif/tb_mem_backend.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_mem_backend -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "sim passed" &&
echo "simulation ok" ||
{ echo "simulation FAILED"; exit 1; }
